//--- hdl/conv_pkg.sv
package conv_pkg;

  ////////////////////////////////////////////////////////////
  // Pixel word and FP32 fields
  ////////////////////////////////////////////////////////////
  localparam int DATA_WIDTH = 32;
  localparam int EXP_WIDTH  = 8;
  localparam int MAN_WIDTH  = 23;
  localparam int EXP_BIAS   = 127;

  ////////////////////////////////////////////////////////////
  // Channel grouping and arithmetic pipeline
  ////////////////////////////////////////////////////////////

  // Planes summed per output pixel
  localparam int CHANNEL_NUM_IN = 3;

  // Cycles from fp_add valid_in to valid_out
  localparam int ADD_LATENCY = 3;

  // Operand class as seen by the adder
  // FP_HUGE covers the all-ones exponent (inf and NaN)
  typedef enum logic [1:0] {
    FP_ZERO   = 2'd0,
    FP_NORMAL = 2'd1,
    FP_HUGE   = 2'd2
  } fp_class_e;

endpackage

//--- hdl/line_buffer.sv
`timescale 1ns/1ns

module line_buffer import conv_pkg::*; #(
  parameter int DEPTH = 64
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_in,
  input  logic [DATA_WIDTH-1:0] data_in,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  valid_out
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [CNT_W-1:0]      fill;
  logic                  full;

  assign full = (fill == CNT_W'(DEPTH));

  // Slot under the write pointer holds the sample from DEPTH strobes ago
  assign data_out  = mem[wr_ptr];
  assign valid_out = valid_in & full;

  always_ff @(posedge clk) begin
    if (valid_in) begin
      mem[wr_ptr] <= data_in;
    end
  end

  // Pointer wraps at DEPTH, fill count stops once full
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      fill   <= '0;
    end else if (valid_in) begin
      if (wr_ptr == PTR_W'(DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (!full) begin
        fill <= fill + 1'b1;
      end
    end
  end

endmodule

//--- hdl/channel_align.sv
`timescale 1ns/1ns

module channel_align import conv_pkg::*; #(
  parameter int IMAGE_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_in,
  input  logic [DATA_WIDTH-1:0] pxl_in,
  output logic [DATA_WIDTH-1:0] tap_0,
  output logic [DATA_WIDTH-1:0] tap_1,
  output logic [DATA_WIDTH-1:0] tap_2,
  output logic                  tap_valid
);

  localparam int PLANE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH;
  localparam int PIX_W      = (PLANE_SIZE > 1) ? $clog2(PLANE_SIZE) : 1;
  localparam int PLANE_W    = $clog2(CHANNEL_NUM_IN);

  localparam logic [PIX_W-1:0]   LAST_PIX   = PIX_W'(PLANE_SIZE - 1);
  localparam logic [PLANE_W-1:0] LAST_PLANE = PLANE_W'(CHANNEL_NUM_IN - 1);

  logic [PIX_W-1:0]   pix_cnt;
  logic [PLANE_W-1:0] plane_idx;
  logic               take_taps;

  ////////////////////////////////////////////////////////////
  // Plane delay chain
  ////////////////////////////////////////////////////////////

  // Index 0 is the live input, index n is the plane n back
  logic [DATA_WIDTH-1:0]     chain_data [CHANNEL_NUM_IN];
  logic [CHANNEL_NUM_IN-1:0] chain_valid;

  assign chain_data[0]  = pxl_in;
  assign chain_valid[0] = valid_in;

  for (genvar i = 0; i < CHANNEL_NUM_IN - 1; i++) begin : g_chain
    line_buffer #(
      .DEPTH(PLANE_SIZE)
    ) u_line_buffer (
      .clk      (clk),
      .reset    (reset),
      .valid_in (chain_valid[i]),
      .data_in  (chain_data[i]),
      .data_out (chain_data[i+1]),
      .valid_out(chain_valid[i+1])
    );
  end

  ////////////////////////////////////////////////////////////
  // Pixel and plane position
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt   <= '0;
      plane_idx <= '0;
    end else if (valid_in) begin
      if (pix_cnt == LAST_PIX) begin
        pix_cnt <= '0;
        if (plane_idx == LAST_PLANE) begin
          plane_idx <= '0;
        end else begin
          plane_idx <= plane_idx + 1'b1;
        end
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  // Third plane of a group, with both older planes present in the chain
  assign take_taps = chain_valid[CHANNEL_NUM_IN-1] && (plane_idx == LAST_PLANE);

  ////////////////////////////////////////////////////////////
  // Aligned tap registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (take_taps) begin
      tap_0 <= chain_data[CHANNEL_NUM_IN-1];
      tap_1 <= chain_data[1];
      tap_2 <= chain_data[0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tap_valid <= 1'b0;
    end else begin
      tap_valid <= take_taps;
    end
  end

endmodule

//--- hdl/fp_add.sv
`timescale 1ns/1ns

module fp_add import conv_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_in,
  input  logic [DATA_WIDTH-1:0] in_a,
  input  logic [DATA_WIDTH-1:0] in_b,
  output logic [DATA_WIDTH-1:0] sum,
  output logic                  valid_out
);

  localparam int MANT_W  = MAN_WIDTH + 1;
  localparam int EXT_W   = MANT_W + 3;
  localparam int SUM_W   = EXT_W + 1;
  localparam int ALIGN_W = 2 * MANT_W + 2;
  localparam int LZ_W    = $clog2(SUM_W + 1);
  localparam int EXPN_W  = EXP_WIDTH + 2;
  localparam int EXP_INF = 2 * EXP_BIAS + 1;

  localparam logic [EXP_WIDTH-1:0] EXP_MAX = EXP_WIDTH'(EXP_INF);

  function automatic fp_class_e classify(input logic [EXP_WIDTH-1:0] e);
    fp_class_e c;
    if (e == '0) begin
      c = FP_ZERO;
    end else if (e == EXP_MAX) begin
      c = FP_HUGE;
    end else begin
      c = FP_NORMAL;
    end
    return c;
  endfunction

  function automatic logic [LZ_W-1:0] lzc(input logic [SUM_W-1:0] v);
    logic [LZ_W-1:0] n;
    logic            hit;
    n   = LZ_W'(SUM_W);
    hit = 1'b0;
    for (int i = SUM_W - 1; i >= 0; i--) begin
      if (!hit && v[i]) begin
        n   = LZ_W'(SUM_W - 1 - i);
        hit = 1'b1;
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stage 1: classify, swap, align
  ////////////////////////////////////////////////////////////
  fp_class_e                cls_a, cls_b;
  logic [DATA_WIDTH-2:0]    mag_a, mag_b;
  logic                     swap;
  logic [DATA_WIDTH-1:0]    op_l, op_s;
  logic [MANT_W-1:0]        man_s;
  logic [EXP_WIDTH-1:0]     exp_diff;
  logic [ALIGN_W-1:0]       align_sh;
  logic [EXT_W-1:0]         man_s_al;

  logic                     s1_valid;
  logic                     s1_sign_l, s1_sign_s;
  logic [EXP_WIDTH-1:0]     s1_exp;
  logic [EXT_W-1:0]         s1_man_l, s1_man_s;
  fp_class_e                s1_cls_l, s1_cls_s;

  always_comb begin
    cls_a = classify(in_a[DATA_WIDTH-2 -: EXP_WIDTH]);
    cls_b = classify(in_b[DATA_WIDTH-2 -: EXP_WIDTH]);
    // Denormals drop to zero magnitude
    mag_a = (cls_a == FP_ZERO) ? '0 : in_a[DATA_WIDTH-2:0];
    mag_b = (cls_b == FP_ZERO) ? '0 : in_b[DATA_WIDTH-2:0];
    swap  = (mag_b > mag_a);
    op_l  = swap ? {in_b[DATA_WIDTH-1], mag_b} : {in_a[DATA_WIDTH-1], mag_a};
    op_s  = swap ? {in_a[DATA_WIDTH-1], mag_a} : {in_b[DATA_WIDTH-1], mag_b};
    man_s = (op_s[DATA_WIDTH-2:0] == '0) ? '0 : {1'b1, op_s[MAN_WIDTH-1:0]};
    exp_diff = op_l[DATA_WIDTH-2 -: EXP_WIDTH] - op_s[DATA_WIDTH-2 -: EXP_WIDTH];
    align_sh = {man_s, {(MANT_W + 2){1'b0}}} >> exp_diff;
    // Far-off operand only survives as sticky
    if (exp_diff > EXP_WIDTH'(MANT_W + 2)) begin
      man_s_al = {{(EXT_W - 1){1'b0}}, |man_s};
    end else begin
      man_s_al = {align_sh[ALIGN_W-1 -: MANT_W+2], |align_sh[MANT_W-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    s1_sign_l <= op_l[DATA_WIDTH-1];
    s1_sign_s <= op_s[DATA_WIDTH-1];
    s1_exp    <= op_l[DATA_WIDTH-2 -: EXP_WIDTH];
    s1_man_l  <= (op_l[DATA_WIDTH-2:0] == '0) ? '0 : {1'b1, op_l[MAN_WIDTH-1:0], 3'b000};
    s1_man_s  <= man_s_al;
    s1_cls_l  <= swap ? cls_b : cls_a;
    s1_cls_s  <= swap ? cls_a : cls_b;
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: magnitude add or subtract, leading zeros
  ////////////////////////////////////////////////////////////
  logic [SUM_W-1:0]     raw;
  logic                 s2_valid;
  logic                 s2_sign;
  logic [EXP_WIDTH-1:0] s2_exp;
  logic [SUM_W-1:0]     s2_raw;
  logic [LZ_W-1:0]      s2_lz;
  fp_class_e            s2_cls;

  always_comb begin
    if (s1_cls_s == FP_ZERO) begin
      raw = {1'b0, s1_man_l};
    end else if (s1_sign_l ^ s1_sign_s) begin
      raw = {1'b0, s1_man_l} - {1'b0, s1_man_s};
    end else begin
      raw = {1'b0, s1_man_l} + {1'b0, s1_man_s};
    end
  end

  always_ff @(posedge clk) begin
    s2_sign <= s1_sign_l;
    s2_exp  <= s1_exp;
    s2_raw  <= raw;
    s2_lz   <= lzc(raw);
    s2_cls  <= s1_cls_l;
  end

  ////////////////////////////////////////////////////////////
  // Stage 3: normalize, round, pack
  ////////////////////////////////////////////////////////////
  logic [EXT_W-1:0]         norm;
  logic [SUM_W-1:0]         norm_sh;
  logic signed [EXPN_W-1:0] exp_n, exp_r;
  logic                     round_up;
  logic [MANT_W:0]          mant_r;
  logic [MAN_WIDTH-1:0]     frac;
  logic [DATA_WIDTH-1:0]    res;

  always_comb begin
    exp_n   = $signed({2'b00, s2_exp});
    norm_sh = s2_raw << (s2_lz - 1'b1);
    if (s2_raw[SUM_W-1]) begin
      // Carry out, shift right one and fold the lost bit into sticky
      norm  = {s2_raw[SUM_W-1:2], s2_raw[1] | s2_raw[0]};
      exp_n = exp_n + 10'sd1;
    end else begin
      norm  = norm_sh[EXT_W-1:0];
      exp_n = exp_n + 10'sd1 - $signed({{(EXPN_W - LZ_W){1'b0}}, s2_lz});
    end
    // Nearest even on guard, round and sticky
    round_up = norm[2] & (norm[3] | norm[1] | norm[0]);
    mant_r   = {1'b0, norm[EXT_W-1:3]} + {{MANT_W{1'b0}}, round_up};
    exp_r    = mant_r[MANT_W] ? exp_n + 10'sd1 : exp_n;
    frac     = mant_r[MANT_W] ? '0 : mant_r[MAN_WIDTH-1:0];
    if (s2_cls == FP_HUGE || exp_r >= EXP_INF) begin
      res = {s2_sign, EXP_MAX, {MAN_WIDTH{1'b0}}};
    end else if (s2_raw == '0 || exp_r <= 0) begin
      res = '0;
    end else begin
      res = {s2_sign, exp_r[EXP_WIDTH-1:0], frac};
    end
  end

  always_ff @(posedge clk) begin
    sum <= res;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      s1_valid  <= valid_in;
      s2_valid  <= s1_valid;
      valid_out <= s2_valid;
    end
  end

endmodule

//--- hdl/channel_sum_tree.sv
`timescale 1ns/1ns

module channel_sum_tree import conv_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [DATA_WIDTH-1:0] tap_0,
  input  logic [DATA_WIDTH-1:0] tap_1,
  input  logic [DATA_WIDTH-1:0] tap_2,
  input  logic                  tap_valid,
  output logic [DATA_WIDTH-1:0] sum,
  output logic                  valid_out
);

  logic [DATA_WIDTH-1:0] partial;
  logic                  partial_valid;

  // tap_2 held back to meet the first partial sum
  logic [DATA_WIDTH-1:0] tap2_dly [ADD_LATENCY];

  ////////////////////////////////////////////////////////////
  // First adder on the two older planes
  ////////////////////////////////////////////////////////////
  fp_add u_fp_add_0 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (tap_valid),
    .in_a     (tap_0),
    .in_b     (tap_1),
    .sum      (partial),
    .valid_out(partial_valid)
  );

  // Free-running shift, so the newest tap lines up with any pulse pattern
  always_ff @(posedge clk) begin
    tap2_dly[0] <= tap_2;
    for (int i = 1; i < ADD_LATENCY; i++) begin
      tap2_dly[i] <= tap2_dly[i-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // Second adder adds in the newest plane
  ////////////////////////////////////////////////////////////
  fp_add u_fp_add_1 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (partial_valid),
    .in_a     (partial),
    .in_b     (tap2_dly[ADD_LATENCY-1]),
    .sum      (sum),
    .valid_out(valid_out)
  );

endmodule

//--- hdl/conv_3channel_adder.sv
`timescale 1ns/1ns

module conv_3channel_adder import conv_pkg::*; #(
  parameter int IMAGE_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_in,
  input  logic [DATA_WIDTH-1:0] pxl_in,
  output logic [DATA_WIDTH-1:0] pxl_out,
  output logic                  valid_out
);

  logic [DATA_WIDTH-1:0] tap_0;
  logic [DATA_WIDTH-1:0] tap_1;
  logic [DATA_WIDTH-1:0] tap_2;
  logic                  tap_valid;

  // Lines up pixel k of the three planes in a group
  channel_align #(
    .IMAGE_WIDTH(IMAGE_WIDTH)
  ) u_channel_align (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .tap_0    (tap_0),
    .tap_1    (tap_1),
    .tap_2    (tap_2),
    .tap_valid(tap_valid)
  );

  channel_sum_tree u_channel_sum_tree (
    .clk      (clk),
    .reset    (reset),
    .tap_0    (tap_0),
    .tap_1    (tap_1),
    .tap_2    (tap_2),
    .tap_valid(tap_valid),
    .sum      (pxl_out),
    .valid_out(valid_out)
  );

endmodule

//--- verification/tb_conv_3channel_adder.sv
`timescale 1ns/1ns

module tb_conv_3channel_adder import conv_pkg::*; ();

  localparam int IMAGE_WIDTH = 4;
  localparam int PIXELS      = IMAGE_WIDTH * IMAGE_WIDTH;
  localparam int TIMEOUT     = 400;

  logic                  clk;
  logic                  reset;
  logic                  valid_in;
  logic [DATA_WIDTH-1:0] pxl_in;
  logic [DATA_WIDTH-1:0] pxl_out;
  logic                  valid_out;

  logic [31:0]           lfsr = 32'd99223;
  int                    cyc = 0;
  int                    planes [6][PIXELS];
  logic [DATA_WIDTH-1:0] res_data [$];
  int                    res_cyc [$];
  int                    third_start;
  int                    errors;
  int                    checks;
  int                    tests;

  conv_3channel_adder #(
    .IMAGE_WIDTH(IMAGE_WIDTH)
  ) u_conv_3channel_adder (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .pxl_out  (pxl_out),
    .valid_out(valid_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Outputs settle after the rising edge, so collect them on the falling one
  always @(negedge clk) begin
    if (valid_out) begin
      res_data.push_back(pxl_out);
      res_cyc.push_back(cyc);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus values
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // Quarter units, so 14 magnitude bits stay below 2^12
  function automatic int random_quarter();
    int mag;
    mag = take_bits(14);
    return (take_bits(1) != 0) ? -mag : mag;
  endfunction

  // Integer count of quarters into FP32 sign, exponent and fraction
  function automatic logic [DATA_WIDTH-1:0] encode_fp32(input int q);
    logic        sign;
    logic [31:0] mag;
    logic [31:0] frac_bits;
    int          msb;
    sign = (q < 0);
    mag  = sign ? -q : q;
    msb  = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) begin
        msb = i;
      end
    end
    frac_bits = mag << (MAN_WIDTH - msb);
    if (mag == 0) begin
      return '0;
    end
    return {sign, EXP_WIDTH'(msb - 2 + EXP_BIAS), frac_bits[MAN_WIDTH-1:0]};
  endfunction

  task automatic fill_random(input int first, input int count);
    for (int p = first; p < first + count; p++) begin
      for (int k = 0; k < PIXELS; k++) begin
        planes[p][k] = random_quarter();
      end
    end
  endtask

  task automatic stream_planes(input int count, input bit gapped);
    int gap;
    for (int p = 0; p < count; p++) begin
      for (int k = 0; k < PIXELS; k++) begin
        gap = gapped ? take_bits(2) : 0;
        for (int g = 0; g < gap; g++) begin
          @(negedge clk);
          valid_in = 1'b0;
        end
        @(negedge clk);
        valid_in = 1'b1;
        pxl_in   = encode_fp32(planes[p][k]);
        if (p == CHANNEL_NUM_IN - 1 && k == 0) begin
          third_start = cyc;
        end
      end
    end
    @(negedge clk);
    valid_in = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Result checking
  ////////////////////////////////////////////////////////////
  task automatic wait_results(input string name, input int n);
    int t;
    int settle;
    t = 0;
    while (res_data.size() < n && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    assert (t < TIMEOUT) else begin
      $display("test %s timed out with %0d of %0d results", name, res_data.size(), n);
      errors++;
    end
    // Room for any stray extra result to drain out
    settle = 0;
    while (settle < 12) begin
      @(negedge clk);
      settle++;
    end
  endtask

  task automatic check_results(input string name, input int groups);
    logic [DATA_WIDTH-1:0] exp_w;
    logic [DATA_WIDTH-1:0] got;
    int                    q;
    assert (res_data.size() == groups * PIXELS) else begin
      $display("test %s expected %0d results but %0d arrived", name, groups * PIXELS,
               res_data.size());
      errors++;
    end
    for (int g = 0; g < groups; g++) begin
      for (int k = 0; k < PIXELS; k++) begin
        if (res_data.size() > 0) begin
          q     = planes[3*g][k] + planes[3*g+1][k] + planes[3*g+2][k];
          exp_w = encode_fp32(q);
          got   = res_data.pop_front();
          checks++;
          assert (got === exp_w) else begin
            $display("ERR %s pixel %0d expected %h actual %h", name, g * PIXELS + k, exp_w, got);
            errors++;
          end
        end
      end
    end
    res_data.delete();
    res_cyc.delete();
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %-14s %s, %0d errors", name, (errors == err_before) ? "ok" : "bad",
             errors - err_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic reset_quiet_test();
    int e;
    e = errors;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      checks++;
      assert (valid_out === 1'b0) else begin
        $display("test reset_quiet saw valid_out high with no input at cycle %0d", i);
        errors++;
      end
    end
    report_test("reset_quiet", e);
  endtask

  task automatic single_group_test();
    int e;
    e = errors;
    fill_random(0, 3);
    stream_planes(3, 1'b0);
    wait_results("single_group", PIXELS);
    checks++;
    assert (res_cyc.size() == 0 || res_cyc[0] > third_start) else begin
      $display("test single_group got a result before the third plane started");
      errors++;
    end
    check_results("single_group", 1);
    report_test("single_group", e);
  endtask

  task automatic sign_cancel_test();
    int e;
    int a;
    int b;
    e = errors;
    for (int k = 0; k < PIXELS; k++) begin
      a = random_quarter();
      b = random_quarter();
      planes[0][k] = a;
      case (k % 4)
        0: begin
          planes[1][k] = -a;
          planes[2][k] = 0;
        end
        1: begin
          planes[1][k] = b;
          planes[2][k] = -(a + b);
        end
        2: begin
          planes[1][k] = -a;
          planes[2][k] = -(2 * k + 1);
        end
        default: begin
          planes[1][k] = b;
          planes[2][k] = 1 - a - b;
        end
      endcase
    end
    stream_planes(3, 1'b0);
    wait_results("sign_cancel", PIXELS);
    check_results("sign_cancel", 1);
    report_test("sign_cancel", e);
  endtask

  task automatic gapped_input_test();
    int e;
    e = errors;
    fill_random(0, 3);
    stream_planes(3, 1'b1);
    wait_results("gapped_input", PIXELS);
    check_results("gapped_input", 1);
    report_test("gapped_input", e);
  endtask

  task automatic back_to_back_test();
    int e;
    e = errors;
    fill_random(0, 6);
    stream_planes(6, 1'b0);
    wait_results("back_to_back", 2 * PIXELS);
    check_results("back_to_back", 2);
    report_test("back_to_back", e);
  endtask

  task automatic latency_test();
    int e;
    e = errors;
    fill_random(0, 3);
    stream_planes(3, 1'b0);
    wait_results("latency", PIXELS);
    if (res_cyc.size() > 0) begin
      checks++;
      assert (res_cyc[0] - third_start == 7) else begin
        $display("ERR latency expected %0d actual %0d", 7, res_cyc[0] - third_start);
        errors++;
      end
    end
    for (int i = 1; i < res_cyc.size(); i++) begin
      assert (res_cyc[i] == res_cyc[0] + i) else begin
        $display("test latency found a gap in the output stream at result %0d", i);
        errors++;
      end
    end
    check_results("latency", 1);
    report_test("latency", e);
  endtask

  initial begin
    reset       = 1'b1;
    valid_in    = 1'b0;
    pxl_in      = '0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    third_start = 0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    reset_quiet_test();
    single_group_test();
    sign_cancel_test();
    gapped_input_test();
    back_to_back_test();
    latency_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
hdl/conv_pkg.sv
hdl/line_buffer.sv
hdl/channel_align.sv
hdl/fp_add.sv
hdl/channel_sum_tree.sv
hdl/conv_3channel_adder.sv
verification/tb_conv_3channel_adder.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_conv_3channel_adder || exit 1
out=$(./obj_dir/Vtb_conv_3channel_adder)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
